//--- Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= cache_tb
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- design/cache_data_store.sv
`timescale 1ns/100ps

module cache_data_store #(
    parameter int s_way = 1,
    localparam int num_ways = 2**s_way
) (
    input  logic                clk,
    input  logic                read_en,
    input  cache_pkg::index_t   read_index,
    input  cache_pkg::index_t   write_index,
    input  logic [num_ways-1:0] way_write,
    input  cache_pkg::line_t    new_line,
    output cache_pkg::line_t    way_lines [num_ways]
);

    localparam int num_sets = 2**cache_pkg::INDEX_BITS;

    cache_pkg::line_t line_q [num_ways][num_sets];

    logic same_index;
    assign same_index = (read_index == write_index);

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (way_write[w]) begin
                line_q[w][write_index] <= new_line;
            end
            // Forward the line being written when both hit one set
            if (read_en) begin
                if (way_write[w] && same_index) begin
                    way_lines[w] <= new_line;
                end else begin
                    way_lines[w] <= line_q[w][read_index];
                end
            end
        end
    end

endmodule

//--- design/cache_pipeline.sv
`timescale 1ns/100ps

module cache_pipeline #(
    parameter int s_way = 1,
    localparam int num_ways = 2**s_way
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // Upstream
    input  logic                    req_valid,
    input  cache_pkg::cache_req_t   req,
    output logic                    req_ready,
    output logic                    rsp_valid,
    output cache_pkg::line_t        rsp_rdata,
    input  logic                    rsp_ready,

    // Downstream
    output logic                    mem_req_valid,
    output cache_pkg::mem_req_t     mem_req,
    input  logic                    mem_req_ready,
    input  logic                    mem_rsp_valid,
    input  cache_pkg::line_t        mem_rsp_rdata,

    // Tag and data stores
    output logic                    read_en,
    output cache_pkg::index_t       read_index,
    output cache_pkg::index_t       write_index,
    output logic [num_ways-1:0]     way_write,
    output cache_pkg::tag_t         new_tag,
    output logic                    new_dirty,
    output cache_pkg::line_t        new_line,
    input  logic [num_ways-1:0]     hit_valid,
    input  logic [num_ways-1:0]     hit_dirty,
    input  cache_pkg::tag_t         way_tags [num_ways],
    input  cache_pkg::line_t        way_lines [num_ways],

    // Replacement
    output cache_pkg::index_t       plru_index,
    output logic                    plru_touch,
    output logic [s_way-1:0]        plru_way,
    input  logic [s_way-1:0]        victim_way
);

    localparam int OFS = cache_pkg::OFFSET_BITS;
    localparam int IDX = cache_pkg::INDEX_BITS;

    // Action stage
    logic                   act_valid;
    cache_pkg::cache_req_t  act_req;
    cache_pkg::miss_state_e state;
    logic                   mem_sent;

    cache_pkg::tag_t   act_tag;
    cache_pkg::index_t act_index;
    logic [num_ways-1:0] hits;
    logic [s_way-1:0]  hit_way;
    logic              hit;
    logic              victim_dirty;
    logic              accept;
    logic              rsp_fire;
    logic              miss_start;
    logic              fill_install;

    assign act_tag   = act_req.addr[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
    assign act_index = act_req.addr[OFS +: IDX];

    // Tag compare against the store outputs
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hits[w] = hit_valid[w] && (way_tags[w] == act_tag);
            if (hits[w]) begin
                hit_way = hit_way | s_way'(w);
            end
        end
    end

    assign hit          = |hits;
    assign victim_dirty = hit_valid[victim_way] && hit_dirty[victim_way];

    assign rsp_valid  = act_valid && (state == cache_pkg::MS_LOOKUP) && hit;
    assign rsp_rdata  = way_lines[hit_way];
    assign rsp_fire   = rsp_valid && rsp_ready;
    assign req_ready  = !act_valid || rsp_fire;
    assign accept     = req_valid && req_ready;
    assign miss_start = act_valid && (state == cache_pkg::MS_LOOKUP) && !hit;

    // Fill data lands on the response pulse of the fill request
    assign fill_install = (state == cache_pkg::MS_FILL) && mem_sent && mem_rsp_valid;

    // Re-read the filled set so the next cycle looks up as a hit
    assign read_en    = accept || fill_install;
    assign read_index = fill_install ? act_index : req.addr[OFS +: IDX];

    assign write_index = act_index;
    assign new_tag     = act_tag;
    assign new_dirty   = act_req.write;
    assign new_line    = (fill_install && !act_req.write) ? mem_rsp_rdata : act_req.wdata;

    always_comb begin
        way_write = '0;
        if (fill_install) begin
            way_write[victim_way] = 1'b1;
        end else if (rsp_fire && act_req.write) begin
            way_write = hits;
        end
    end

    // Every completed access updates the replacement tree
    assign plru_index = act_index;
    assign plru_touch = rsp_fire;
    assign plru_way   = hit_way;

    // Downstream request, built from held store outputs
    assign mem_req_valid = ((state == cache_pkg::MS_EVICT) ||
                            (state == cache_pkg::MS_FILL)) && !mem_sent;
    assign mem_req.write = (state == cache_pkg::MS_EVICT);
    assign mem_req.addr  = (state == cache_pkg::MS_EVICT)
                         ? {way_tags[victim_way], act_index, {OFS{1'b0}}}
                         : {act_tag, act_index, {OFS{1'b0}}};
    assign mem_req.wdata = way_lines[victim_way];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            act_valid <= 1'b0;
            state     <= cache_pkg::MS_LOOKUP;
            mem_sent  <= 1'b0;
        end else begin
            if (accept) begin
                act_valid <= 1'b1;
            end else if (rsp_fire) begin
                act_valid <= 1'b0;
            end

            case (state)
                cache_pkg::MS_LOOKUP: begin
                    if (miss_start) begin
                        state <= victim_dirty ? cache_pkg::MS_EVICT : cache_pkg::MS_FILL;
                    end
                end
                cache_pkg::MS_EVICT: begin
                    if (mem_sent && mem_rsp_valid) begin
                        state <= cache_pkg::MS_FILL;
                    end
                end
                cache_pkg::MS_FILL: begin
                    if (fill_install) begin
                        state <= cache_pkg::MS_LOOKUP;
                    end
                end
                default: state <= cache_pkg::MS_LOOKUP;
            endcase

            // One memory request outstanding at a time
            if (mem_req_valid && mem_req_ready) begin
                mem_sent <= 1'b1;
            end else if (mem_rsp_valid) begin
                mem_sent <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            act_req <= req;
        end
    end

    // Stores never hold the same tag twice in one set
    assert property (@(posedge clk) disable iff (!rst_n)
        act_valid |-> $onehot0(hits));

    assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)));

endmodule

//--- design/cache_pkg.sv
package cache_pkg;

    // Address split for 8-byte lines and 8 sets
    localparam int ADDR_BITS   = 32;
    localparam int LINE_BITS   = 64;
    localparam int OFFSET_BITS = 3;
    localparam int INDEX_BITS  = 3;
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [LINE_BITS-1:0]  line_t;
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    // Upstream request, wdata only matters on writes
    typedef struct packed {
        logic  write;
        addr_t addr;
        line_t wdata;
    } cache_req_t;

    // Downstream request, write set for a write-back
    typedef struct packed {
        logic  write;
        addr_t addr;
        line_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        MS_LOOKUP,
        MS_EVICT,
        MS_FILL
    } miss_state_e;

endpackage

//--- design/cache_plru.sv
`timescale 1ns/100ps

module cache_plru #(
    parameter int s_way = 1,
    localparam int num_ways = 2**s_way
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cache_pkg::index_t plru_index,
    input  logic              plru_touch,
    input  logic [s_way-1:0]  plru_way,
    output logic [s_way-1:0]  victim_way
);

    localparam int num_sets = 2**cache_pkg::INDEX_BITS;

    // Node n has children 2n+1 and 2n+2, a clear bit points left
    logic [num_ways-2:0] tree_q [num_sets];
    logic [num_ways-2:0] tree_cur;
    logic [num_ways-2:0] tree_next;

    assign tree_cur = tree_q[plru_index];

    // Walk down the tree to the least recently used leaf
    always_comb begin
        int node;
        node = 0;
        for (int lvl = 0; lvl < s_way; lvl++) begin
            victim_way[s_way-1-lvl] = tree_cur[node];
            node = 2*node + 1 + int'(tree_cur[node]);
        end
    end

    // Point every node on the touched path at the other half
    always_comb begin
        int node;
        logic dir;
        node      = 0;
        tree_next = tree_cur;
        for (int lvl = 0; lvl < s_way; lvl++) begin
            dir             = plru_way[s_way-1-lvl];
            tree_next[node] = ~dir;
            node            = 2*node + 1 + int'(dir);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_q[s] <= '0;
            end
        end else if (plru_touch) begin
            tree_q[plru_index] <= tree_next;
        end
    end

    // A legal touched way never comes back as the victim of its own set
    assert property (@(posedge clk) disable iff (!rst_n)
        plru_touch |-> (int'(plru_way) < num_ways) ##1
            ((plru_index != $past(plru_index)) || (victim_way != $past(plru_way))));

endmodule

//--- design/cache_tag_store.sv
`timescale 1ns/100ps

module cache_tag_store #(
    parameter int s_way = 1,
    localparam int num_ways = 2**s_way
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                read_en,
    input  cache_pkg::index_t   read_index,
    input  cache_pkg::index_t   write_index,
    input  logic [num_ways-1:0] way_write,
    input  cache_pkg::tag_t     new_tag,
    input  logic                new_dirty,
    output logic [num_ways-1:0] hit_valid,
    output logic [num_ways-1:0] hit_dirty,
    output cache_pkg::tag_t     way_tags [num_ways]
);

    localparam int num_sets = 2**cache_pkg::INDEX_BITS;

    logic            valid_q [num_ways][num_sets];
    logic            dirty_q [num_ways][num_sets];
    cache_pkg::tag_t tag_q   [num_ways][num_sets];

    // Read of the set under write sees the new entry
    logic same_index;
    assign same_index = (read_index == write_index);

    // Valid bits and their registered read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < num_ways; w++) begin
                for (int s = 0; s < num_sets; s++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
            hit_valid <= '0;
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_write[w]) begin
                    valid_q[w][write_index] <= 1'b1;
                end
                if (read_en) begin
                    hit_valid[w] <= (way_write[w] && same_index) ? 1'b1
                                                                 : valid_q[w][read_index];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (way_write[w]) begin
                dirty_q[w][write_index] <= new_dirty;
                tag_q[w][write_index]   <= new_tag;
            end
            if (read_en) begin
                if (way_write[w] && same_index) begin
                    hit_dirty[w] <= new_dirty;
                    way_tags[w]  <= new_tag;
                end else begin
                    hit_dirty[w] <= dirty_q[w][read_index];
                    way_tags[w]  <= tag_q[w][read_index];
                end
            end
        end
    end

endmodule

//--- design/cache_top.sv
`timescale 1ns/100ps

module cache_top #(
    parameter int s_way = 1,
    localparam int num_ways = 2**s_way
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  cache_pkg::cache_req_t req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output cache_pkg::line_t      rsp_rdata,
    input  logic                  rsp_ready,
    output logic                  mem_req_valid,
    output cache_pkg::mem_req_t   mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  cache_pkg::line_t      mem_rsp_rdata
);

    logic                read_en;
    cache_pkg::index_t   read_index;
    cache_pkg::index_t   write_index;
    logic [num_ways-1:0] way_write;
    cache_pkg::tag_t     new_tag;
    logic                new_dirty;
    cache_pkg::line_t    new_line;
    logic [num_ways-1:0] hit_valid;
    logic [num_ways-1:0] hit_dirty;
    cache_pkg::tag_t     way_tags [num_ways];
    cache_pkg::line_t    way_lines [num_ways];
    cache_pkg::index_t   plru_index;
    logic                plru_touch;
    logic [s_way-1:0]    plru_way;
    logic [s_way-1:0]    victim_way;

    cache_pipeline #(.s_way(s_way)) i_pipeline (
        .clk, .rst_n,
        .req_valid, .req, .req_ready,
        .rsp_valid, .rsp_rdata, .rsp_ready,
        .mem_req_valid, .mem_req, .mem_req_ready,
        .mem_rsp_valid, .mem_rsp_rdata,
        .read_en, .read_index, .write_index, .way_write,
        .new_tag, .new_dirty, .new_line,
        .hit_valid, .hit_dirty, .way_tags, .way_lines,
        .plru_index, .plru_touch, .plru_way, .victim_way
    );

    cache_tag_store #(.s_way(s_way)) i_tag_store (
        .clk, .rst_n,
        .read_en, .read_index, .write_index, .way_write,
        .new_tag, .new_dirty,
        .hit_valid, .hit_dirty, .way_tags
    );

    cache_data_store #(.s_way(s_way)) i_data_store (
        .clk,
        .read_en, .read_index, .write_index, .way_write,
        .new_line, .way_lines
    );

    cache_plru #(.s_way(s_way)) i_plru (
        .clk, .rst_n,
        .plru_index, .plru_touch, .plru_way, .victim_way
    );

endmodule

//--- dv/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    localparam int NUM_REQ    = 4 + 3 + 3 + 6 + 300;
    localparam int MAX_CYCLES = 40 * NUM_REQ + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    cache_pkg::cache_req_t req;
    logic                  req_ready;
    logic                  rsp_valid;
    cache_pkg::line_t      rsp_rdata;
    logic                  rsp_ready;
    logic                  mem_req_valid;
    cache_pkg::mem_req_t   mem_req;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    cache_pkg::line_t      mem_rsp_rdata;
    logic [2:0]            mem_latency;
    int                    wb_count;

    logic [15:0] lfsr_q;
    string       test_name;
    int          cycles = 0;
    int          exp_wb;

    // Expected responses and memory requests in arrival order
    cache_pkg::cache_req_t rsp_q [$];
    cache_pkg::mem_req_t   mem_q [$];

    // Shadow memory and the set model with its replacement bit
    cache_pkg::line_t shadow  [64];
    logic             written [64];
    logic             m_valid [8][2];
    logic [2:0]       m_tag   [8][2];
    logic             m_dirty [8][2];
    logic             m_lru   [8];

    cache_top #(.s_way(1)) i_dut (.*);

    mem_model i_mem (
        .clk, .rst_n, .latency(mem_latency),
        .mem_req_valid, .mem_req, .mem_req_ready,
        .mem_rsp_valid, .mem_rsp_rdata, .wb_count
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    // A read returns the last line written there or the initial pattern
    function automatic cache_pkg::line_t ref_read(input cache_pkg::addr_t a);
        if (written[a[8:3]]) begin
            return shadow[a[8:3]];
        end
        return (64'(a[8:3]) * 64'h0101_0101_0101_0101) ^ 64'hA5A5_0000_5A5A_0000;
    endfunction

    function automatic cache_pkg::addr_t mk_addr(input logic [2:0] tag, input logic [2:0] idx);
        return {23'b0, tag, idx, 3'b000};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t exp,
                              input cache_pkg::line_t act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t exp,
                              input cache_pkg::addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic set_pace();
        rsp_ready   = (lfsr_bits(2) != 0);
        mem_latency = 3'(lfsr_bits(3));
    endtask

    // Predict hit, eviction and fill at acceptance and then update the shadow
    task automatic predict(input cache_pkg::cache_req_t r);
        int                    idx;
        int                    w;
        cache_pkg::mem_req_t   m;
        cache_pkg::cache_req_t e;
        idx = int'(r.addr[5:3]);
        w   = -1;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[idx][i] && m_tag[idx][i] == r.addr[8:6]) begin
                w = i;
            end
        end
        if (w < 0) begin
            w = int'(m_lru[idx]);
            if (m_valid[idx][w] && m_dirty[idx][w]) begin
                m.write = 1'b1;
                m.addr  = mk_addr(m_tag[idx][w], r.addr[5:3]);
                m.wdata = ref_read(m.addr);
                mem_q.push_back(m);
                exp_wb++;
            end
            m.write = 1'b0;
            m.addr  = {r.addr[31:3], 3'b000};
            m.wdata = '0;
            mem_q.push_back(m);
            m_valid[idx][w] = 1'b1;
            m_tag[idx][w]   = r.addr[8:6];
            m_dirty[idx][w] = 1'b0;
        end
        if (r.write) begin
            m_dirty[idx][w] = 1'b1;
        end
        m_lru[idx] = (w == 0);
        e       = r;
        e.wdata = ref_read(r.addr);
        rsp_q.push_back(e);
        if (r.write) begin
            shadow[r.addr[8:3]]  = r.wdata;
            written[r.addr[8:3]] = 1'b1;
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after acceptance
    task automatic send(input logic wr, input logic [2:0] tag, input logic [2:0] idx,
                        input cache_pkg::line_t data);
        set_pace();
        req_valid = 1'b1;
        req.write = wr;
        req.addr  = mk_addr(tag, idx);
        req.wdata = data;
        #1;
        while (!req_ready) begin
            @(negedge clk);
            set_pace();
            #1;
        end
        predict(req);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (rsp_q.size() != 0 || mem_q.size() != 0) begin
            @(negedge clk);
            set_pace();
        end
        @(negedge clk);
        if (wb_count != exp_wb) begin
            fail_run($sformatf("FAIL %s: write-back count expected %0d, actual %0d",
                               test_name, exp_wb, wb_count));
        end
    endtask

    // Compare responses and memory requests where they are stable
    always @(negedge clk) begin
        cache_pkg::cache_req_t e;
        cache_pkg::mem_req_t   m;
        #1;
        if (rst_n && rsp_valid && rsp_ready) begin
            if (rsp_q.size() == 0) begin
                fail_run({test_name, ": response with no request outstanding"});
            end else begin
                e = rsp_q.pop_front();
                if (!e.write) begin
                    check_line(test_name, e.wdata, rsp_rdata);
                end
            end
        end
        if (rst_n && mem_req_valid && mem_req_ready) begin
            if (mem_q.size() == 0) begin
                fail_run({test_name, ": memory request that the model did not expect"});
            end else begin
                m = mem_q.pop_front();
                if (m.write !== mem_req.write) begin
                    fail_run($sformatf("FAIL %s: request write bit expected %0b, actual %0b",
                                       test_name, m.write, mem_req.write));
                end else begin
                    check_addr(test_name, m.addr, mem_req.addr);
                    if (m.write) begin
                        check_line(test_name, m.wdata, mem_req.wdata);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_run({test_name, ": run hit the cycle limit"});
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        rsp_ready   = 1'b0;
        mem_latency = '0;
        lfsr_q      = 16'd27;
        exp_wb      = 0;
        test_name   = "reset";
        for (int i = 0; i < 64; i++) begin
            written[i] = 1'b0;
        end
        for (int s = 0; s < 8; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_name = "read_miss_hit";
        send(0, 1, 2, '0);
        send(0, 1, 2, '0);
        send(0, 2, 3, '0);
        send(0, 2, 3, '0);
        drain();

        test_name = "write_hit_read";
        send(0, 3, 4, '0);
        send(1, 3, 4, 64'h1111_2222_3333_4444);
        send(0, 3, 4, '0);
        drain();

        // Third tag in one set pushes out the dirty first line
        test_name = "dirty_evict";
        send(1, 1, 5, 64'hAAAA_0000_0000_0001);
        send(1, 2, 5, 64'hBBBB_0000_0000_0002);
        send(1, 3, 5, 64'hCCCC_0000_0000_0003);
        drain();

        test_name = "plru_order";
        send(0, 1, 6, '0);
        send(0, 2, 6, '0);
        send(0, 1, 6, '0);
        send(0, 3, 6, '0);
        send(0, 1, 6, '0);
        send(0, 2, 6, '0);
        drain();

        test_name = "random_traffic";
        for (int n = 0; n < 300; n++) begin
            send(1'(lfsr_bits(1)), 3'(lfsr_bits(2)), 3'(lfsr_bits(2)),
                 {lfsr_bits(32), lfsr_bits(32)});
        end
        drain();

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- dv/mem_model.sv
`timescale 1ns/100ps

module mem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [2:0]          latency,
    input  logic                mem_req_valid,
    input  cache_pkg::mem_req_t mem_req,
    output logic                mem_req_ready,
    output logic                mem_rsp_valid,
    output cache_pkg::line_t    mem_rsp_rdata,
    output int                  wb_count
);

    cache_pkg::line_t    mem [64];
    cache_pkg::mem_req_t cur;
    logic                busy;
    logic [2:0]          cnt;
    logic [2:0]          gap;

    // One request at a time and none until the gap after a response runs out
    assign mem_req_ready = !busy && (gap == 0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Every byte holds the line index under a fixed mask
            for (int i = 0; i < 64; i++) begin
                mem[i] <= (64'(i) * 64'h0101_0101_0101_0101) ^ 64'hA5A5_0000_5A5A_0000;
            end
            busy          <= 1'b0;
            cnt           <= '0;
            gap           <= '0;
            mem_rsp_valid <= 1'b0;
            wb_count      <= 0;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (gap != 0) begin
                gap <= gap - 1'b1;
            end
            if (mem_req_valid && mem_req_ready) begin
                busy <= 1'b1;
                cur  <= mem_req;
                cnt  <= latency;
            end else if (busy) begin
                if (cnt == 0) begin
                    busy          <= 1'b0;
                    gap           <= latency;
                    mem_rsp_valid <= 1'b1;
                    if (cur.write) begin
                        mem[cur.addr[8:3]] <= cur.wdata;
                        wb_count           <= wb_count + 1;
                    end else begin
                        mem_rsp_rdata <= mem[cur.addr[8:3]];
                    end
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

endmodule

//--- src.f
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_plru.sv
design/cache_pipeline.sv
design/cache_top.sv
dv/mem_model.sv
dv/cache_tb.sv
